// File: include/lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// display geometry
`define LCD_LINE_CHARS 16
`define LCD_WORDS_PER_LINE 4

// hold durations in microseconds
`define LCD_POWER_ON_US 15000
`define LCD_WAKE_FIRST_US 5000
`define LCD_WAKE_SECOND_US 500
`define LCD_CMD_US 200
`define LCD_CLEAR_US 3000

`endif

// File: rtl/lcd_pkg.sv
`include "lcd_defines.svh"

package lcd_pkg;

	typedef logic [7:0] lcd_char_t;
	typedef logic [3:0] lcd_nibble_t;
	typedef logic [$clog2(`LCD_LINE_CHARS)-1:0] lcd_col_t;

	typedef enum logic {ROW_UPPER, ROW_LOWER} lcd_row_e;

	typedef enum logic [1:0] {
		OP_WAIT, // hold only, no E pulse
		OP_NIBBLE, // upper nibble only
		OP_BYTE // upper then lower nibble
	} lcd_op_e;

	typedef enum logic [2:0] {
		HOLD_POWER_ON,
		HOLD_WAKE_FIRST,
		HOLD_WAKE_SECOND,
		HOLD_CMD,
		HOLD_CLEAR
	} lcd_hold_e;

	typedef enum logic [7:0] {
		CMD_WAKE = 8'h30,
		CMD_FOUR_BIT = 8'h20,
		CMD_FUNCTION_SET = 8'h28, // 4 bit, 2 lines, 5x8
		CMD_DISPLAY_ON = 8'h0F, // cursor and blink on
		CMD_CLEAR = 8'h01,
		CMD_ENTRY_MODE = 8'h06, // increment, no shift
		CMD_ROW_UPPER = 8'h80,
		CMD_ROW_LOWER = 8'hC0
	} lcd_cmd_e;

	typedef enum logic [3:0] {
		SEQ_POWER_ON,
		SEQ_WAKE_1,
		SEQ_WAKE_2,
		SEQ_WAKE_3,
		SEQ_FOUR_BIT,
		SEQ_FUNCTION_SET,
		SEQ_DISPLAY_ON,
		SEQ_CLEAR,
		SEQ_ENTRY_MODE,
		SEQ_CURSOR_UPPER,
		SEQ_WRITE_UPPER,
		SEQ_CURSOR_LOWER,
		SEQ_WRITE_LOWER,
		SEQ_WAIT_VALID
	} lcd_seq_state_e;

endpackage

// File: rtl/lcd_xfer_if.sv
`timescale 1ns/1ps

interface lcd_xfer_if;
	import lcd_pkg::*;

	logic start; // one cycle, opens a transfer
	lcd_op_e op;
	lcd_hold_e hold;
	logic is_data; // becomes RS
	lcd_cmd_e cmd;
	logic done; // one cycle, hold has ended

	modport sequencer (
		output start, op, hold, is_data, cmd,
		input done
	);

	modport writer (
		input start, op, hold, is_data, cmd,
		output done
	);

endinterface

// File: rtl/lcd_text_buffer.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_text_buffer (
	input logic clk,
	input logic rst,
	input logic load,
	input logic [31:0] lcd_data_str_0_0,
	input logic [31:0] lcd_data_str_0_1,
	input logic [31:0] lcd_data_str_0_2,
	input logic [31:0] lcd_data_str_0_3,
	input logic [31:0] lcd_data_str_1_0,
	input logic [31:0] lcd_data_str_1_1,
	input logic [31:0] lcd_data_str_1_2,
	input logic [31:0] lcd_data_str_1_3,
	input lcd_pkg::lcd_row_e row,
	input lcd_pkg::lcd_col_t col,
	output lcd_pkg::lcd_char_t char_out
);
	import lcd_pkg::*;

	localparam int bytes_per_word = `LCD_LINE_CHARS / `LCD_WORDS_PER_LINE;
	localparam logic [8*`LCD_LINE_CHARS-1:0] upper_text = "Firmware loaded!";
	localparam logic [8*`LCD_LINE_CHARS-1:0] lower_text = "0123456789abcdef";

	logic [31:0] upper_words [`LCD_WORDS_PER_LINE];
	logic [31:0] lower_words [`LCD_WORDS_PER_LINE];
	lcd_char_t upper_line [`LCD_LINE_CHARS];
	lcd_char_t lower_line [`LCD_LINE_CHARS];

	assign upper_words[0] = lcd_data_str_0_0;
	assign upper_words[1] = lcd_data_str_0_1;
	assign upper_words[2] = lcd_data_str_0_2;
	assign upper_words[3] = lcd_data_str_0_3;
	assign lower_words[0] = lcd_data_str_1_0;
	assign lower_words[1] = lcd_data_str_1_1;
	assign lower_words[2] = lcd_data_str_1_2;
	assign lower_words[3] = lcd_data_str_1_3;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
				// string literal keeps the first character in the top byte
				upper_line[k] <= upper_text[8*(`LCD_LINE_CHARS-1-k) +: 8];
				lower_line[k] <= lower_text[8*(`LCD_LINE_CHARS-1-k) +: 8];
			end
		end else if (load) begin
			for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
				upper_line[k] <= upper_words[k/bytes_per_word][8*(k%bytes_per_word) +: 8];
				lower_line[k] <= lower_words[k/bytes_per_word][8*(k%bytes_per_word) +: 8];
			end
		end
	end

	assign char_out = (row == ROW_UPPER) ? upper_line[col] : lower_line[col];

endmodule

// File: rtl/lcd_sequencer.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_sequencer (
	input logic clk,
	input logic rst,
	lcd_xfer_if.sequencer xfer,
	output lcd_pkg::lcd_row_e row,
	output lcd_pkg::lcd_col_t col,
	output logic load,
	output logic lcd_ready,
	input logic lcd_valid
);
	import lcd_pkg::*;

	lcd_seq_state_e state;
	lcd_seq_state_e state_after;
	logic start_r;
	logic last_col;
	logic writing;

	assign last_col = (col == lcd_col_t'(`LCD_LINE_CHARS - 1));
	assign writing = (state == SEQ_WRITE_UPPER) || (state == SEQ_WRITE_LOWER);
	assign load = lcd_ready & lcd_valid;
	assign xfer.start = start_r;

	// transfer fields for the current state
	always_comb begin
		xfer.op = OP_BYTE;
		xfer.hold = HOLD_CMD;
		xfer.is_data = 1'b0;
		xfer.cmd = CMD_WAKE;
		row = ROW_UPPER;
		case (state)
			SEQ_POWER_ON: begin
				xfer.op = OP_WAIT;
				xfer.hold = HOLD_POWER_ON;
			end
			SEQ_WAKE_1: begin
				xfer.op = OP_NIBBLE;
				xfer.hold = HOLD_WAKE_FIRST;
			end
			SEQ_WAKE_2: begin
				xfer.op = OP_NIBBLE;
				xfer.hold = HOLD_WAKE_SECOND;
			end
			SEQ_WAKE_3: xfer.op = OP_NIBBLE;
			SEQ_FOUR_BIT: begin
				xfer.op = OP_NIBBLE;
				xfer.cmd = CMD_FOUR_BIT;
			end
			SEQ_FUNCTION_SET: xfer.cmd = CMD_FUNCTION_SET;
			SEQ_DISPLAY_ON: xfer.cmd = CMD_DISPLAY_ON;
			SEQ_CLEAR: begin
				xfer.cmd = CMD_CLEAR;
				xfer.hold = HOLD_CLEAR; // clear needs the long wait
			end
			SEQ_ENTRY_MODE: xfer.cmd = CMD_ENTRY_MODE;
			SEQ_CURSOR_UPPER: xfer.cmd = CMD_ROW_UPPER;
			SEQ_WRITE_UPPER: xfer.is_data = 1'b1;
			SEQ_CURSOR_LOWER: xfer.cmd = CMD_ROW_LOWER;
			SEQ_WRITE_LOWER: begin
				xfer.is_data = 1'b1;
				row = ROW_LOWER;
			end
			default: xfer.op = OP_WAIT; // idle, nothing is started
		endcase
	end

	always_comb begin
		case (state)
			SEQ_POWER_ON: state_after = SEQ_WAKE_1;
			SEQ_WAKE_1: state_after = SEQ_WAKE_2;
			SEQ_WAKE_2: state_after = SEQ_WAKE_3;
			SEQ_WAKE_3: state_after = SEQ_FOUR_BIT;
			SEQ_FOUR_BIT: state_after = SEQ_FUNCTION_SET;
			SEQ_FUNCTION_SET: state_after = SEQ_DISPLAY_ON;
			SEQ_DISPLAY_ON: state_after = SEQ_CLEAR;
			SEQ_CLEAR: state_after = SEQ_ENTRY_MODE;
			SEQ_ENTRY_MODE: state_after = SEQ_CURSOR_UPPER;
			SEQ_CURSOR_UPPER: state_after = SEQ_WRITE_UPPER;
			SEQ_WRITE_UPPER: state_after = last_col ? SEQ_CURSOR_LOWER : SEQ_WRITE_UPPER;
			SEQ_CURSOR_LOWER: state_after = SEQ_WRITE_LOWER;
			SEQ_WRITE_LOWER: state_after = last_col ? SEQ_WAIT_VALID : SEQ_WRITE_LOWER;
			default: state_after = SEQ_CURSOR_UPPER; // redraw after a load
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= SEQ_POWER_ON;
			col <= '0;
			start_r <= 1'b1; // kicks off the power-on wait
			lcd_ready <= 1'b0;
		end else begin
			start_r <= 1'b0;
			if (xfer.done) begin
				state <= state_after;
				if (writing) begin
					col <= last_col ? '0 : col + 1'b1;
				end
				if (state_after == SEQ_WAIT_VALID) begin
					lcd_ready <= 1'b1;
				end else begin
					start_r <= 1'b1;
				end
			end else if (load) begin
				state <= state_after;
				lcd_ready <= 1'b0;
				start_r <= 1'b1;
			end
		end
	end

endmodule

// File: rtl/lcd_bus_writer.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_bus_writer #(
	parameter int cycles_per_us = 50
) (
	input logic clk,
	input logic rst,
	lcd_xfer_if.writer xfer,
	input lcd_pkg::lcd_char_t char_in,
	output logic [2:0] ctrl_lcd,
	output lcd_pkg::lcd_nibble_t data_lcd
);
	import lcd_pkg::*;

	localparam logic [31:0] u = 32'(cycles_per_us);

	logic busy;
	logic done_r;
	logic [31:0] cnt;
	logic [31:0] hold_us;
	logic [31:0] hold_cycles;
	lcd_char_t byte_r;
	logic e;
	logic rs;

	always_comb begin
		case (xfer.hold)
			HOLD_POWER_ON: hold_us = `LCD_POWER_ON_US;
			HOLD_WAKE_FIRST: hold_us = `LCD_WAKE_FIRST_US;
			HOLD_WAKE_SECOND: hold_us = `LCD_WAKE_SECOND_US;
			HOLD_CLEAR: hold_us = `LCD_CLEAR_US;
			default: hold_us = `LCD_CMD_US;
		endcase
	end

	assign hold_cycles = hold_us * u;

	// one counter covers the pulse windows and the hold
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done_r <= 1'b0;
			cnt <= '0;
		end else begin
			done_r <= 1'b0;
			if (xfer.start) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				if (cnt == hold_cycles - 32'd1) begin
					busy <= 1'b0;
					done_r <= 1'b1;
				end else begin
					cnt <= cnt + 32'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (xfer.start) begin
			byte_r <= xfer.is_data ? char_in : lcd_char_t'(xfer.cmd);
		end
	end

	always_comb begin
		e = 1'b0;
		data_lcd = '0;
		if (busy) begin
			case (xfer.op)
				OP_NIBBLE: begin
					e = (cnt < u);
					if (cnt < 2*u) begin
						data_lcd = byte_r[7:4];
					end
				end
				OP_BYTE: begin
					e = (cnt < u) || (cnt >= 2*u && cnt < 3*u);
					if (cnt < 2*u) begin
						data_lcd = byte_r[7:4];
					end else if (cnt < 4*u) begin
						data_lcd = byte_r[3:0];
					end
				end
				default: e = 1'b0; // plain wait
			endcase
		end
	end

	assign rs = e & xfer.is_data; // RS only shown with E
	assign ctrl_lcd = {rs, 1'b0, e}; // RW tied low
	assign xfer.done = done_r;

endmodule

// File: rtl/lcd_panel.sv
`timescale 1ns/1ps

module lcd_panel #(
	parameter int cycles_per_us = 50
) (
	input logic clk,
	input logic rst,
	output logic [2:0] ctrl_lcd,
	output logic [3:0] data_lcd,
	output logic lcd_ready,
	input logic lcd_valid,
	input logic [31:0] lcd_data_str_0_0,
	input logic [31:0] lcd_data_str_0_1,
	input logic [31:0] lcd_data_str_0_2,
	input logic [31:0] lcd_data_str_0_3,
	input logic [31:0] lcd_data_str_1_0,
	input logic [31:0] lcd_data_str_1_1,
	input logic [31:0] lcd_data_str_1_2,
	input logic [31:0] lcd_data_str_1_3
);
	import lcd_pkg::*;

	lcd_row_e row;
	lcd_col_t col;
	lcd_char_t char_sel; // character at row, col
	logic load;

	lcd_xfer_if xfer ();

	lcd_sequencer i_lcd_sequencer (
		.clk (clk),
		.rst (rst),
		.xfer (xfer.sequencer),
		.row (row),
		.col (col),
		.load (load),
		.lcd_ready (lcd_ready),
		.lcd_valid (lcd_valid)
	);

	lcd_text_buffer i_lcd_text_buffer (
		.clk (clk),
		.rst (rst),
		.load (load),
		.lcd_data_str_0_0 (lcd_data_str_0_0),
		.lcd_data_str_0_1 (lcd_data_str_0_1),
		.lcd_data_str_0_2 (lcd_data_str_0_2),
		.lcd_data_str_0_3 (lcd_data_str_0_3),
		.lcd_data_str_1_0 (lcd_data_str_1_0),
		.lcd_data_str_1_1 (lcd_data_str_1_1),
		.lcd_data_str_1_2 (lcd_data_str_1_2),
		.lcd_data_str_1_3 (lcd_data_str_1_3),
		.row (row),
		.col (col),
		.char_out (char_sel)
	);

	lcd_bus_writer #(
		.cycles_per_us (cycles_per_us)
	) i_lcd_bus_writer (
		.clk (clk),
		.rst (rst),
		.xfer (xfer.writer),
		.char_in (char_sel),
		.ctrl_lcd (ctrl_lcd),
		.data_lcd (data_lcd)
	);

endmodule

// File: dv/lcd_panel_assert.sv
`timescale 1ns/1ps

module lcd_panel_assert #(
	parameter int cycles_per_us = 1
) (
	input logic clk,
	input logic rst,
	input logic [2:0] ctrl_lcd,
	input logic lcd_ready
);

	logic e;
	logic rw;
	logic rs;
	int failures = 0; // count of failed assertions

	assign e = ctrl_lcd[0];
	assign rw = ctrl_lcd[1];
	assign rs = ctrl_lcd[2];

	rw_low: assert property (@(posedge clk) disable iff (rst) !rw)
		else begin
			$error("RW driven high");
			failures++;
		end

	rs_only_with_e: assert property (@(posedge clk) disable iff (rst) rs |-> e)
		else begin
			$error("RS high while E is low");
			failures++;
		end

	// every enable pulse is exactly one microsecond wide
	e_width: assert property (@(posedge clk) disable iff (rst)
		$rose(e) |-> e [*cycles_per_us] ##1 !e)
		else begin
			$error("E pulse width differs from cycles_per_us");
			failures++;
		end

	ready_idle_bus: assert property (@(posedge clk) disable iff (rst) e |-> !lcd_ready)
		else begin
			$error("lcd_ready high during an E pulse");
			failures++;
		end

endmodule

bind lcd_panel lcd_panel_assert #(
	.cycles_per_us (cycles_per_us)
) i_lcd_panel_assert (
	.clk (clk),
	.rst (rst),
	.ctrl_lcd (ctrl_lcd),
	.lcd_ready (lcd_ready)
);

// File: dv/lcd_panel_tb.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_panel_tb;
	import lcd_pkg::*;

	localparam int cycles_per_us = 2;
	localparam int wait_limit = 40000; // longer than any single hold
	localparam int bytes_per_word = `LCD_LINE_CHARS / `LCD_WORDS_PER_LINE;

	logic clk;
	logic rst;
	logic [2:0] ctrl_lcd;
	logic [3:0] data_lcd;
	logic lcd_ready;
	logic lcd_valid;
	logic [31:0] str_words [2*`LCD_WORDS_PER_LINE];

	logic [31:0] lfsr_state;
	logic [4:0] captured [$]; // {RS, nibble} per E pulse
	logic [4:0] e_high_value;
	logic e_was_high;
	lcd_char_t upper_exp [`LCD_LINE_CHARS];
	lcd_char_t lower_exp [`LCD_LINE_CHARS];
	int checks;
	int errors;
	int tests;
	int errors_before;

	lcd_panel #(
		.cycles_per_us (cycles_per_us)
	) i_lcd_panel (
		.clk (clk),
		.rst (rst),
		.ctrl_lcd (ctrl_lcd),
		.data_lcd (data_lcd),
		.lcd_ready (lcd_ready),
		.lcd_valid (lcd_valid),
		.lcd_data_str_0_0 (str_words[0]),
		.lcd_data_str_0_1 (str_words[1]),
		.lcd_data_str_0_2 (str_words[2]),
		.lcd_data_str_0_3 (str_words[3]),
		.lcd_data_str_1_0 (str_words[4]),
		.lcd_data_str_1_1 (str_words[5]),
		.lcd_data_str_1_2 (str_words[6]),
		.lcd_data_str_1_3 (str_words[7])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// bus monitor, keeps the value seen while E was high
	always @(negedge clk) begin
		if (rst) begin
			e_was_high = 1'b0;
		end else if (ctrl_lcd[0]) begin
			e_was_high = 1'b1;
			e_high_value = {ctrl_lcd[2], data_lcd};
		end else if (e_was_high) begin
			e_was_high = 1'b0;
			captured.push_back(e_high_value);
		end
	end

	function automatic logic [31:0] galois_step(logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003; // x^32 + x^22 + x^2 + x + 1
		end
		return s >> 1;
	endfunction

	task automatic next_word(output logic [31:0] w);
		w = '0;
		for (int b = 0; b < 32; b++) begin
			w = {w[30:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
	endtask

	task automatic check_cmd(string what, lcd_cmd_e got, lcd_cmd_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_char(string what, lcd_char_t got, lcd_char_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(string what, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_pins(string what, logic [2:0] ctrl, lcd_nibble_t data);
		checks++;
		if (ctrl !== 3'b000 || data !== 4'h0) begin
			errors++;
			$display("Fail at %0d ns: %s got ctrl %b data %h expected all zero",
				$time, what, ctrl, data);
		end
	endtask

	task automatic check_min_cycles(string what, int got, int min);
		checks++;
		if (got < min) begin
			errors++;
			$display("Fail at %0d ns: %s got %0d expected at least %0d", $time, what, got, min);
		end
	endtask

	task automatic abort_run(string msg);
		$display("Timeout: %s", msg);
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors + 1);
		$display("Test failed");
		$finish;
	endtask

	task automatic finish_test(string name);
		tests++;
		$display("%s: %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	task automatic wait_entries(int n);
		int cycles;
		cycles = 0;
		while (captured.size() < n) begin
			@(posedge clk);
			cycles++;
			if (cycles > wait_limit) begin
				abort_run("no E pulse on the bus for too long");
			end
		end
	endtask

	task automatic wait_ready(logic level);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (lcd_ready !== level) begin
			@(negedge clk);
			cycles++;
			if (cycles > wait_limit) begin
				abort_run("lcd_ready never reached the expected level");
			end
		end
	endtask

	task automatic send_valid_pulse();
		@(negedge clk);
		lcd_valid = 1'b1;
		@(negedge clk);
		lcd_valid = 1'b0;
	endtask

	task automatic expect_nibble(lcd_cmd_e exp);
		logic [4:0] v;
		wait_entries(1);
		v = captured.pop_front();
		check_flag("RS of init nibble", v[4], 1'b0);
		check_cmd("init nibble", lcd_cmd_e'({v[3:0], 4'h0}), exp);
	endtask

	task automatic pop_byte(output lcd_char_t b, output logic rs);
		logic [4:0] hi;
		logic [4:0] lo;
		wait_entries(2);
		hi = captured.pop_front();
		lo = captured.pop_front();
		check_flag("RS same on both nibbles", lo[4], hi[4]);
		b = {hi[3:0], lo[3:0]};
		rs = hi[4];
	endtask

	task automatic expect_cmd(lcd_cmd_e exp);
		lcd_char_t b;
		logic rs;
		pop_byte(b, rs);
		check_flag($sformatf("RS of %s", exp.name()), rs, 1'b0);
		check_cmd("command byte", lcd_cmd_e'(b), exp);
	endtask

	task automatic expect_char(lcd_char_t exp, string where);
		lcd_char_t b;
		logic rs;
		pop_byte(b, rs);
		check_flag({"RS of ", where}, rs, 1'b1);
		check_char(where, b, exp);
	endtask

	task automatic expect_frame();
		expect_cmd(CMD_ROW_UPPER);
		for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
			expect_char(upper_exp[k], $sformatf("upper char %0d", k));
		end
		expect_cmd(CMD_ROW_LOWER);
		for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
			expect_char(lower_exp[k], $sformatf("lower char %0d", k));
		end
	endtask

	task automatic expect_default_text();
		string upper;
		string lower;
		upper = "Firmware loaded!";
		lower = "0123456789abcdef";
		for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
			upper_exp[k] = upper[k];
			lower_exp[k] = lower[k];
		end
	endtask

	// byte 0 of each word is the leftmost character
	task automatic expect_words_text();
		for (int k = 0; k < `LCD_LINE_CHARS; k++) begin
			upper_exp[k] = str_words[k / bytes_per_word][8*(k % bytes_per_word) +: 8];
			lower_exp[k] = str_words[`LCD_WORDS_PER_LINE + k / bytes_per_word]
				[8*(k % bytes_per_word) +: 8];
		end
	endtask

	task automatic test_reset_state();
		int cycles;
		check_pins("pins after reset", ctrl_lcd, data_lcd);
		check_flag("lcd_ready after reset", lcd_ready, 1'b0);
		cycles = 0;
		while (!ctrl_lcd[0]) begin
			@(negedge clk);
			cycles++;
			if (cycles > `LCD_POWER_ON_US * cycles_per_us + wait_limit) begin
				abort_run("no E pulse after the power-on wait");
			end
		end
		check_min_cycles("cycles to first E", cycles, `LCD_POWER_ON_US * cycles_per_us);
		finish_test("reset state");
	endtask

	task automatic test_init();
		expect_nibble(CMD_WAKE);
		expect_nibble(CMD_WAKE);
		expect_nibble(CMD_WAKE);
		expect_nibble(CMD_FOUR_BIT);
		expect_cmd(CMD_FUNCTION_SET);
		expect_cmd(CMD_DISPLAY_ON);
		expect_cmd(CMD_CLEAR);
		expect_cmd(CMD_ENTRY_MODE);
		finish_test("initialisation");
	endtask

	task automatic test_default_frame();
		expect_default_text();
		expect_frame();
		wait_ready(1'b1);
		check_flag("no extra E pulses", captured.size() == 0, 1'b1);
		finish_test("default frame");
	endtask

	task automatic test_load();
		wait_ready(1'b1);
		for (int i = 0; i < 2*`LCD_WORDS_PER_LINE; i++) begin
			next_word(str_words[i]);
		end
		send_valid_pulse();
		check_flag("lcd_ready after valid", lcd_ready, 1'b0);
		expect_words_text();
		expect_frame();
		wait_ready(1'b1);
		check_flag("no extra E pulses", captured.size() == 0, 1'b1);
		finish_test("load");
	endtask

	task automatic test_ignored_valid();
		logic [31:0] kept [2*`LCD_WORDS_PER_LINE];
		kept = str_words;
		send_valid_pulse(); // same words, starts a new frame
		wait_entries(4);
		@(negedge clk);
		for (int i = 0; i < 2*`LCD_WORDS_PER_LINE; i++) begin
			next_word(str_words[i]);
		end
		lcd_valid = 1'b1;
		repeat (200) @(negedge clk);
		check_flag("lcd_ready during frame", lcd_ready, 1'b0);
		lcd_valid = 1'b0;
		expect_frame();
		wait_ready(1'b1);
		str_words = kept; // other words stay on the inputs until here
		send_valid_pulse();
		expect_frame();
		wait_ready(1'b1);
		check_flag("no extra E pulses", captured.size() == 0, 1'b1);
		finish_test("ignored valid");
	endtask

	initial begin
		rst = 1'b1;
		lcd_valid = 1'b0;
		for (int i = 0; i < 2*`LCD_WORDS_PER_LINE; i++) begin
			str_words[i] = '0;
		end
		lfsr_state = 32'd98369;
		checks = 0;
		errors = 0;
		tests = 0;
		errors_before = 0;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		test_reset_state();
		test_init();
		test_default_frame();
		test_load();
		test_ignored_valid();
		errors += i_lcd_panel.i_lcd_panel_assert.failures;
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+include
rtl/lcd_pkg.sv
rtl/lcd_xfer_if.sv
rtl/lcd_text_buffer.sv
rtl/lcd_sequencer.sv
rtl/lcd_bus_writer.sv
rtl/lcd_panel.sv
dv/lcd_panel_assert.sv
dv/lcd_panel_tb.sv
